// File: tests/buf_pool_tb.sv
`timescale 1ns/1ps
`include "buf_pool_consts.svh"

// testbench for the buffer pool
// a queue of free pointers is the reference and the pointer on free_ptr
// is checked against its head on every allocation
module buf_pool_tb import buf_pool_pkg::*; ();

    localparam int WAIT_LIMIT = 200;   // cycles any single wait may take
    localparam int W_DONE     = 0;     // wait_until selects init_done
    localparam int W_EMPTY    = 1;     // wait_until selects free_empty

    logic       clk;
    logic       rst;
    logic       init;
    rel_req_t   rel;
    logic       alloc;
    logic       init_done;
    logic       free_empty;
    buf_ptr_t   free_ptr;
    pool_stat_t stat;

    buf_ptr_t    model_q[$];   // free pointers in the order they must come out
    buf_ptr_t    held_q[$];    // pointers handed out and not yet released
    int          mcnt;         // free count as the status block should see it
    int          mlow;         // lowest mcnt since init_done last rose
    logic        rel_d1;       // release seen one cycle ago
    logic        rel_d2;
    logic        done_q;
    int          mismatch_cnt;
    int          other_cnt;
    logic [31:0] lcg_state;

    buf_pool u_buf_pool (
        .clk        (clk),
        .rst        (rst),
        .init       (init),
        .rel        (rel),
        .alloc      (alloc),
        .init_done  (init_done),
        .free_empty (free_empty),
        .free_ptr   (free_ptr),
        .stat       (stat)
    );

    always #20 clk = ~clk;   // 40 ns period

    // --------------------
    // reference model
    // --------------------
    // the head the pool must hand out next and the number of free pointers
    function automatic void ref_state(output buf_ptr_t head, output int unsigned len);
        len  = model_q.size();
        head = (len > 0) ? model_q[0] : '0;
    endfunction

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // the status lags a release by two more cycles than an allocation,
    // so the count model delays releases to follow the low watermark
    always @(negedge clk) begin : compare_model
        buf_ptr_t    exp_head;
        int unsigned exp_len;
        logic        took;
        if (rst) begin
            model_q.delete();
            held_q.delete();
            mcnt   = 0;
            mlow   = 0;
            rel_d1 = 1'b0;
            rel_d2 = 1'b0;
            done_q = 1'b0;
        end else begin
            if (init_done && !done_q) begin   // a fresh fill holds 0 .. 15 in order
                model_q.delete();
                for (int i = 0; i < `BUF_POOL_SIZE; i++) model_q.push_back(buf_ptr_t'(i));
                mcnt   = `BUF_POOL_SIZE;
                mlow   = `BUF_POOL_SIZE;
                rel_d1 = 1'b0;
                rel_d2 = 1'b0;
            end
            done_q = init_done;
            took = alloc && init_done && !free_empty;
            ref_state(exp_head, exp_len);
            if (init_done && !free_empty) begin
                assert (exp_len > 0) else begin
                    other_cnt++;
                    $display("at %0t the pool shows a free pointer the model does not have",
                             $time);
                end
            end
            if (took) begin
                assert (free_ptr == exp_head) else begin
                    mismatch_cnt++;
                    $display("mismatch at %0t: free_ptr expected %0d got %0d",
                             $time, exp_head, free_ptr);
                end
                if (exp_len > 0) begin
                    void'(model_q.pop_front());
                    held_q.push_back(exp_head);   // the client now owns it
                end
            end
            if (rel.valid) model_q.push_back(rel.ptr);   // releases go to the tail
            mcnt = mcnt + int'(rel_d2) - int'(took);
            if (mcnt < mlow) mlow = mcnt;
            rel_d2 = rel_d1;
            rel_d1 = rel.valid;
            if (init && init_done) begin   // accepted re-init forgets every pointer
                model_q.delete();
                held_q.delete();
            end
        end
    end

    // --------------------
    // helper tasks
    // --------------------
    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // waits at falling edges for init_done or free_empty to reach a level
    task automatic wait_until(input int sel, input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (((sel == W_DONE) ? init_done : free_empty) !== level && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (((sel == W_DONE) ? init_done : free_empty) !== level) begin
            other_cnt++;
            $display("timeout at %0t: %s never went to %0b", $time,
                     (sel == W_DONE) ? "init_done" : "free_empty", level);
            finish_run();
        end else begin
            @(posedge clk);
        end
    endtask

    // holds alloc high until n allocations have been accepted
    task automatic take_ptrs(input int n);
        int taken;
        int waited;
        taken  = 0;
        waited = 0;
        alloc <= 1'b1;
        while (taken < n && waited < WAIT_LIMIT) begin
            @(negedge clk);
            if (alloc && init_done && !free_empty) taken++;
            waited++;
        end
        if (taken < n) begin
            other_cnt++;
            $display("timeout at %0t: only %0d of %0d allocations accepted", $time, taken, n);
            finish_run();
        end else begin
            @(posedge clk);
            alloc <= 1'b0;
        end
    endtask

    // gives back every held pointer newest first at one per cycle
    task automatic release_all();
        while (held_q.size() > 0) begin
            rel.valid <= 1'b1;
            rel.ptr   <= held_q.pop_back();
            @(posedge clk);
        end
        rel.valid <= 1'b0;
    endtask

    // lets the pipeline drain and then compares the status with the model
    task automatic check_idle();
        buf_ptr_t    head;
        int unsigned len;
        alloc     <= 1'b0;
        rel.valid <= 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        ref_state(head, len);
        assert (stat.free_cnt == len) else begin
            mismatch_cnt++;
            $display("mismatch at %0t: stat.free_cnt expected %0d got %0d",
                     $time, len, stat.free_cnt);
        end
        assert (stat.low_mark == mlow) else begin
            mismatch_cnt++;
            $display("mismatch at %0t: stat.low_mark expected %0d got %0d",
                     $time, mlow, stat.low_mark);
        end
        assert (free_empty == (len == 0)) else begin
            mismatch_cnt++;
            $display("mismatch at %0t: free_empty expected %0b got %0b",
                     $time, (len == 0), free_empty);
        end
        @(posedge clk);
    endtask

    // the generator picks random allocations and releases
    task automatic random_traffic(input int cycles);
        int idx;
        repeat (cycles) begin
            lcg_state = lcg_step(lcg_state);
            alloc <= (lcg_state[19:17] < 3'd5);   // upper bits since the low ones repeat quickly
            if (lcg_state[20] && held_q.size() > 0) begin
                idx = lcg_state[27:24] % held_q.size();
                rel.valid <= 1'b1;
                rel.ptr   <= held_q[idx];
                held_q.delete(idx);
            end else begin
                rel.valid <= 1'b0;
            end
            @(posedge clk);
        end
    endtask

    // --------------------
    // stimulus
    // --------------------
    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        init         = 1'b0;
        rel          = '0;
        alloc        = 1'b0;
        mismatch_cnt = 0;
        other_cnt    = 0;
        lcg_state    = 32'h2c4c;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        wait_until(W_DONE, 1'b1);

        take_ptrs(`BUF_POOL_SIZE);   // a fresh pool gives 0 .. 15 in order
        wait_until(W_EMPTY, 1'b1);
        check_idle();

        release_all();               // 15 .. 0 must come back in that order
        check_idle();
        take_ptrs(`BUF_POOL_SIZE);
        release_all();
        take_ptrs(6);
        check_idle();

        random_traffic(150);
        check_idle();
        random_traffic(150);
        check_idle();

        init <= 1'b1;                // re-init while pointers are still out
        @(posedge clk);
        init <= 1'b0;
        wait_until(W_DONE, 1'b0);
        wait_until(W_DONE, 1'b1);
        check_idle();                // full pool again with a free count of 16
        take_ptrs(`BUF_POOL_SIZE);
        wait_until(W_EMPTY, 1'b1);
        check_idle();

        finish_run();
    end

endmodule

// File: verilog.f
+incdir+verilog
verilog/buf_pool_pkg.sv
verilog/ram_fifo.sv
verilog/prefetch_fifo.sv
verilog/free_list.sv
verilog/buf_occupancy.sv
verilog/buf_pool.sv
tests/buf_pool_tb.sv

// File: verilog/buf_occupancy.sv
`timescale 1ns/1ps
`include "buf_pool_consts.svh"

// free pointer count and low watermark, built from the increment pulses
module buf_occupancy import buf_pool_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       clear,    // re-init strobe that zeroes both fields
    input  logic       inc_rd,   // one pointer handed out
    input  logic       inc_wr,   // one pointer written back
    output pool_stat_t stat
);

    buf_cnt_t cnt_nxt;
    logic     armed;   // set by the first allocation after a clear

    // a read and a write in the same cycle cancel out
    assign cnt_nxt = stat.free_cnt + buf_cnt_t'(inc_wr) - buf_cnt_t'(inc_rd);

    // --------------------
    // count and watermark
    // --------------------
    // the fill only raises the count and no allocation happens before
    // init_done, so until the first read low_mark just follows the count
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            stat  <= '0;
            armed <= 1'b0;
        end else begin
            stat.free_cnt <= cnt_nxt;
            if (!armed || cnt_nxt < stat.low_mark) begin
                stat.low_mark <= cnt_nxt;
            end
            if (inc_rd) begin
                armed <= 1'b1;   // from here on low_mark only falls
            end
        end
    end

endmodule

// File: verilog/buf_pool.sv
`timescale 1ns/1ps
`include "buf_pool_consts.svh"

// buffer pool manager top with the free list and its occupancy status
module buf_pool import buf_pool_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       init,
    input  rel_req_t   rel,
    input  logic       alloc,
    output logic       init_done,
    output logic       free_empty,
    output buf_ptr_t   free_ptr,
    output pool_stat_t stat
);

    logic inc_rd;
    logic inc_wr;
    logic stat_clr;

    // the free list ignores init until it is done, so the status does too
    assign stat_clr = init && init_done;

    // --------------------
    // free list
    // --------------------
    free_list u_free_list (
        .clk        (clk),
        .rst        (rst),
        .init       (init),
        .rel        (rel),
        .alloc      (alloc),
        .inc_rd     (inc_rd),
        .inc_wr     (inc_wr),
        .init_done  (init_done),
        .free_empty (free_empty),
        .free_ptr   (free_ptr)
    );

    // --------------------
    // status
    // --------------------
    buf_occupancy u_buf_occupancy (
        .clk    (clk),
        .rst    (rst),
        .clear  (stat_clr),
        .inc_rd (inc_rd),
        .inc_wr (inc_wr),
        .stat   (stat)
    );

endmodule

// File: verilog/buf_pool_consts.svh
`ifndef BUF_POOL_CONSTS_SVH
`define BUF_POOL_CONSTS_SVH

// sizing of the buffer pool

// --------------------
// pointer and pool size
// --------------------
`define BUF_PTR_NBITS   4   // one pointer addresses every buffer in the pool
`define BUF_POOL_SIZE   16  // must stay 2**BUF_PTR_NBITS so the ram fifo pointers wrap freely

// words held ahead of the ram fifo so the head has no read latency
`define PREFETCH_DEPTH  2

`endif

// File: verilog/buf_pool_pkg.sv
`include "buf_pool_consts.svh"

// types shared by the free list, the occupancy block and the top
package buf_pool_pkg;

    // --------------------
    // pointers and counts
    // --------------------

    // one buffer pointer that doubles as the ram fifo address
    typedef logic [`BUF_PTR_NBITS-1:0] buf_ptr_t;

    // wide enough to hold a full pool, so 16 needs 5 bits
    typedef logic [$clog2(`BUF_POOL_SIZE + 1)-1:0] buf_cnt_t;

    // --------------------
    // client and status
    // --------------------

    // a released buffer with a one cycle valid strobe
    typedef struct packed {
        logic     valid;
        buf_ptr_t ptr;
    } rel_req_t;

    // pool status seen by software
    typedef struct packed {
        buf_cnt_t free_cnt;   // free pointers right now
        buf_cnt_t low_mark;   // lowest free_cnt since the last init
    } pool_stat_t;

endpackage

// File: verilog/free_list.sv
`timescale 1ns/1ps
`include "buf_pool_consts.svh"

// free pointer list
// an init machine fills the ram fifo with 0 .. 15, releases go back into
// the same fifo, and a prefetch fifo keeps the next pointer on free_ptr
// with no read latency
module free_list import buf_pool_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     init,        // honoured only in the done state
    input  rel_req_t rel,
    input  logic     alloc,
    output logic     inc_rd,      // same cycle as the allocation
    output logic     inc_wr,      // one cycle after the ram write
    output logic     init_done,
    output logic     free_empty,
    output buf_ptr_t free_ptr
);

    typedef enum logic [1:0] {
        INIT_IDLE  = 2'd0,
        INIT_CLEAR = 2'd1,
        INIT_FILL  = 2'd2,
        INIT_DONE  = 2'd3
    } init_st_t;

    init_st_t init_st;
    init_st_t init_nxt;

    logic     fifo_clr;     // one cycle clear of both fifos
    logic     fifo_rst;
    logic     init_wr;      // fill write that stays high for 16 cycles
    rel_req_t rel_q;
    logic     fifo_wr;
    logic     fifo_rd;
    logic     fifo_rd_q;    // the word read last cycle lands in the prefetch fifo now
    logic     fifo_empty;
    buf_ptr_t fifo_din;
    buf_ptr_t fifo_dout;
    buf_ptr_t fifo_wptr;
    logic     pf_rd;
    logic     pf_full;
    logic     pf_fullm1;

    // --------------------
    // init state machine
    // --------------------
    always_comb begin
        init_nxt = init_st;
        case (init_st)
            INIT_IDLE:  init_nxt = INIT_CLEAR;
            INIT_CLEAR: init_nxt = INIT_FILL;
            // the last fill write goes to the top slot
            INIT_FILL:  if (fifo_wptr == buf_ptr_t'(`BUF_POOL_SIZE - 1)) init_nxt = INIT_DONE;
            INIT_DONE:  if (init) init_nxt = INIT_IDLE;
            default:    init_nxt = INIT_IDLE;
        endcase
    end

    // the machine outputs are registered from the next state
    always_ff @(posedge clk) begin
        if (rst) begin
            init_st   <= INIT_IDLE;
            fifo_clr  <= 1'b0;
            init_wr   <= 1'b0;
            init_done <= 1'b0;
        end else begin
            init_st   <= init_nxt;
            fifo_clr  <= (init_nxt == INIT_CLEAR);
            init_wr   <= (init_nxt == INIT_FILL);
            init_done <= (init_nxt == INIT_DONE);
        end
    end

    assign fifo_rst = rst || fifo_clr;

    // --------------------
    // write side
    // --------------------
    // a release reaches the ram fifo one cycle after it arrives
    always_ff @(posedge clk) begin
        if (rst) rel_q.valid <= 1'b0;
        else     rel_q       <= rel;
    end

    assign fifo_wr  = init_wr || rel_q.valid;
    assign fifo_din = init_wr ? fifo_wptr : rel_q.ptr;   // fill writes the address itself

    // --------------------
    // read side
    // --------------------
    // stall while a word in flight would overfill the prefetch fifo
    assign fifo_rd = !init_wr && !fifo_empty && !(pf_full || (fifo_rd_q && pf_fullm1));
    assign pf_rd   = init_done && alloc && !free_empty;   // an alloc on empty is ignored
    assign inc_rd  = pf_rd;

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            fifo_rd_q <= 1'b0;   // a clear also drops the word in flight
            inc_wr    <= 1'b0;
        end else begin
            fifo_rd_q <= fifo_rd;
            inc_wr    <= fifo_wr;
        end
    end

    ram_fifo u_ram_fifo (
        .clk   (clk),
        .rst   (fifo_rst),
        .wr    (fifo_wr),
        .rd    (fifo_rd),
        .din   (fifo_din),
        .dout  (fifo_dout),
        .wptr  (fifo_wptr),
        .count (),
        .full  (),   // a full pool cannot take a release anyway
        .empty (fifo_empty)
    );

    prefetch_fifo #(.DEPTH(`PREFETCH_DEPTH)) u_prefetch_fifo (
        .clk    (clk),
        .rst    (fifo_rst),
        .wr     (fifo_rd_q),
        .rd     (pf_rd),
        .din    (fifo_dout),
        .dout   (free_ptr),
        .full   (pf_full),
        .fullm1 (pf_fullm1),
        .empty  (free_empty)
    );

endmodule

// File: verilog/prefetch_fifo.sv
`timescale 1ns/1ps
`include "buf_pool_consts.svh"

// shallow register fifo in first word fall through style
// the head word sits on dout as soon as it is written and rd just pops it
module prefetch_fifo import buf_pool_pkg::*; #(
    parameter int DEPTH = `PREFETCH_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     wr,
    input  logic     rd,
    input  buf_ptr_t din,
    output buf_ptr_t dout,
    output logic     full,
    output logic     fullm1,   // one slot left so the feeder can count a word in flight
    output logic     empty
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // slot index width
    localparam int CW = $clog2(DEPTH + 1);                // count reaches DEPTH

    buf_ptr_t      mem [DEPTH];
    logic [PW-1:0] wptr;
    logic [PW-1:0] rptr;
    logic [CW-1:0] cnt;
    logic          do_wr;
    logic          do_rd;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    assign dout   = mem[rptr];   // no latency on the head
    assign full   = (cnt == CW'(DEPTH));
    assign fullm1 = (cnt == CW'(DEPTH - 1));
    assign empty  = (cnt == '0);

    // --------------------
    // pointers and count
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wptr <= '0;
            rptr <= '0;
            cnt  <= '0;
        end else begin
            if (do_wr) wptr <= ptr_inc(wptr);
            if (do_rd) rptr <= ptr_inc(rptr);
            case ({do_wr, do_rd})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

    // slot registers written at the tail
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wptr] <= din;
        end
    end

endmodule

// File: verilog/ram_fifo.sv
`timescale 1ns/1ps
`include "buf_pool_consts.svh"

// circular fifo over a register array that stores the free pointers
// the read data is registered, so a word shows at dout one cycle after rd
module ram_fifo import buf_pool_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     wr,
    input  logic     rd,
    input  buf_ptr_t din,
    output buf_ptr_t dout,
    output buf_ptr_t wptr,    // the init fill writes this value as data
    output buf_cnt_t count,
    output logic     full,
    output logic     empty
);

    // --------------------
    // storage and pointers
    // --------------------
    buf_ptr_t mem [`BUF_POOL_SIZE];
    buf_ptr_t rptr;

    logic do_wr;
    logic do_rd;

    assign do_wr = wr && !full;   // a write into a full fifo is dropped
    assign do_rd = rd && !empty;  // reading an empty fifo leaves dout alone

    // flags come straight from the occupancy count
    assign full  = (count == buf_cnt_t'(`BUF_POOL_SIZE));
    assign empty = (count == '0);

    // --------------------
    // control
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            // the pointers are as wide as the address so they wrap on their own
            if (do_wr) begin
                wptr <= wptr + 1'b1;
            end
            if (do_rd) begin
                rptr <= rptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle, or one in and one out
            endcase
        end
    end

    // --------------------
    // array
    // --------------------
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rptr];   // registered read port
        end
    end

endmodule
